// ==== common/remips_defs.svh ====
`ifndef REMIPS_DEFS_SVH
`define REMIPS_DEFS_SVH

// instruction cache geometry
`define ICACHE_LINES    16
`define LINE_WORDS      4
`define ICACHE_INDEX_W  4
`define ICACHE_TAG_W    24

// read ids on the AXI bus, one per source
`define AXI_ID_INST     4'd0
`define AXI_ID_DATA     4'd1

// segment bits 31:29 of an uncached address
`define KSEG1_TOP       3'b101

`endif

// ==== common/remips_pkg.sv ====
package remips_pkg;

    typedef logic [31:0]  virt_t;
    typedef logic [31:0]  phys_t;
    typedef logic [31:0]  uint32_t;
    typedef logic [127:0] uint128_t;
    typedef logic [3:0]   strb_t;
    typedef logic [2:0]   size_t;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_REFILL,
        IC_BYPASS
    } icache_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } bridge_rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } bridge_wr_state_e;

    // kseg0 and kseg1 both map onto the low 512 MB
    function automatic phys_t to_phys(virt_t va);
        return {3'b000, va[28:0]};
    endfunction

endpackage

// ==== icache/icache.sv ====
`timescale 1ns/10ps
`include "remips_defs.svh"

module icache (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_req,
    input  remips_pkg::virt_t    inst_addr,
    output logic                 inst_addr_ok,
    output logic                 inst_data_ok,
    output remips_pkg::uint32_t  inst_rdata,
    output logic                 rd_req,
    output logic                 rd_uncache,
    output remips_pkg::phys_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  remips_pkg::uint128_t ret_data
);
    import remips_pkg::*;

    localparam int OFF_W   = $clog2(`LINE_WORDS);
    localparam int TAG_LSB = 32 - `ICACHE_TAG_W;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    icache_state_e             state;
    phys_t                     req_addr;
    logic                      rd_sent;
    tag_t                      tag_arr [`ICACHE_LINES];
    uint128_t                  line_arr [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]  valid_arr;
    logic [`ICACHE_INDEX_W-1:0] idx;
    logic [OFF_W-1:0]          off;
    logic                      hit;
    logic                      accept;
    logic                      to_bypass;

    assign idx       = req_addr[OFF_W+2 +: `ICACHE_INDEX_W];
    assign off       = req_addr[2 +: OFF_W];
    assign to_bypass = inst_addr[31:29] == `KSEG1_TOP;

    // tag compare happens the cycle after acceptance
    assign hit = state == IC_LOOKUP && valid_arr[idx] && tag_arr[idx] == req_addr[31:TAG_LSB];

    assign inst_addr_ok = state == IC_IDLE || hit;
    assign accept       = inst_req && inst_addr_ok;
    assign inst_data_ok = hit || (state == IC_BYPASS && ret_valid);
    assign inst_rdata   = state == IC_BYPASS ? ret_data[31:0] : line_arr[idx][off*32 +: 32];

    assign rd_req     = (state == IC_REFILL || state == IC_BYPASS) && !rd_sent;
    assign rd_uncache = state == IC_BYPASS;
    assign rd_addr    = rd_uncache ? req_addr : {req_addr[31:OFF_W+2], {(OFF_W+2){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IC_IDLE;
            rd_sent   <= 1'b0;
            valid_arr <= '0;
        end else begin
            if (rd_req && rd_rdy) begin
                rd_sent <= 1'b1;
            end else if (ret_valid) begin
                rd_sent <= 1'b0;
            end
            case (state)
                IC_IDLE, IC_LOOKUP: begin
                    if (accept) begin
                        state <= to_bypass ? IC_BYPASS : IC_LOOKUP;
                    end else if (state == IC_LOOKUP && !hit) begin
                        state <= IC_REFILL;
                    end else begin
                        state <= IC_IDLE;
                    end
                end
                IC_REFILL: begin
                    // look up again so the hit path delivers the word
                    if (ret_valid) begin
                        valid_arr[idx] <= 1'b1;
                        state          <= IC_LOOKUP;
                    end
                end
                IC_BYPASS: begin
                    if (ret_valid) begin
                        state <= IC_IDLE;
                    end
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= to_phys(inst_addr);
        end
        if (state == IC_REFILL && ret_valid) begin
            tag_arr[idx]  <= req_addr[31:TAG_LSB];
            line_arr[idx] <= ret_data;
        end
    end

    // a return only comes for a read the bridge has taken
    a_ret_pending: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> rd_sent);

    // refilled line must hit on the next lookup
    a_refill_hits: assert property (@(posedge clk) disable iff (rst)
        state == IC_REFILL && ret_valid |=> hit);

endmodule

// ==== src/uncache_port.sv ====
`timescale 1ns/10ps

module uncache_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                data_req,
    input  logic                data_wr,
    input  remips_pkg::size_t   data_size,
    input  remips_pkg::strb_t   data_wstrb,
    input  remips_pkg::virt_t   data_addr,
    input  remips_pkg::uint32_t data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    output remips_pkg::uint32_t data_rdata,
    output logic                urd_req,
    output remips_pkg::phys_t   urd_addr,
    output remips_pkg::size_t   urd_size,
    input  logic                urd_rdy,
    input  logic                uret_valid,
    input  remips_pkg::uint32_t uret_data,
    output logic                uwr_req,
    output remips_pkg::phys_t   uwr_addr,
    output remips_pkg::size_t   uwr_size,
    output remips_pkg::strb_t   uwr_wstrb,
    output remips_pkg::uint32_t uwr_data,
    input  logic                uwr_rdy,
    input  logic                uwr_bvalid
);
    import remips_pkg::*;

    logic    busy;
    logic    sent;
    logic    is_wr;
    phys_t   addr_q;
    size_t   size_q;
    strb_t   wstrb_q;
    uint32_t wdata_q;

    assign data_addr_ok = !busy;
    assign urd_req      = busy && !sent && !is_wr;
    assign uwr_req      = busy && !sent && is_wr;
    assign urd_addr     = addr_q;
    assign uwr_addr     = addr_q;
    assign urd_size     = size_q;
    assign uwr_size     = size_q;
    assign uwr_wstrb    = wstrb_q;
    assign uwr_data     = wdata_q;

    // writes finish on the b response, reads on the returned word
    assign data_data_ok = busy && sent && (is_wr ? uwr_bvalid : uret_valid);
    assign data_rdata   = uret_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            sent <= 1'b0;
        end else begin
            if (data_req && data_addr_ok) begin
                busy <= 1'b1;
                sent <= 1'b0;
            end else if (data_data_ok) begin
                busy <= 1'b0;
            end
            if ((urd_req && urd_rdy) || (uwr_req && uwr_rdy)) begin
                sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_req && data_addr_ok) begin
            is_wr   <= data_wr;
            addr_q  <= to_phys(data_addr);
            size_q  <= data_size;
            wstrb_q <= data_wstrb;
            wdata_q <= data_wdata;
        end
    end

    // a return or write response only comes for the entry in flight
    a_ret_for_entry: assert property (@(posedge clk) disable iff (rst)
        uret_valid || uwr_bvalid |-> busy && sent && (is_wr ? uwr_bvalid : uret_valid));

endmodule

// ==== src/axi_bridge.sv ====
`timescale 1ns/10ps
`include "remips_defs.svh"

module axi_bridge (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd_req,
    input  logic                 rd_uncache,
    input  remips_pkg::phys_t    rd_addr,
    output logic                 rd_rdy,
    output logic                 ret_valid,
    output remips_pkg::uint128_t ret_data,
    input  logic                 urd_req,
    input  remips_pkg::phys_t    urd_addr,
    input  remips_pkg::size_t    urd_size,
    output logic                 urd_rdy,
    output logic                 uret_valid,
    output remips_pkg::uint32_t  uret_data,
    input  logic                 uwr_req,
    input  remips_pkg::phys_t    uwr_addr,
    input  remips_pkg::size_t    uwr_size,
    input  remips_pkg::strb_t    uwr_wstrb,
    input  remips_pkg::uint32_t  uwr_data,
    output logic                 uwr_rdy,
    output logic                 uwr_bvalid,
    // ar
    output logic [3:0]           arid,
    output remips_pkg::phys_t    araddr,
    output logic [7:0]           arlen,
    output remips_pkg::size_t    arsize,
    output logic                 arvalid,
    input  logic                 arready,
    // r
    input  logic [3:0]           rid,
    input  remips_pkg::uint32_t  rdata,
    input  logic [1:0]           rresp,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready,
    // aw
    output logic [3:0]           awid,
    output remips_pkg::phys_t    awaddr,
    output logic [7:0]           awlen,
    output remips_pkg::size_t    awsize,
    output logic                 awvalid,
    input  logic                 awready,
    // w
    output logic [3:0]           wid,
    output remips_pkg::uint32_t  wdata,
    output remips_pkg::strb_t    wstrb,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,
    // b
    input  logic [3:0]           bid,
    input  logic [1:0]           bresp,
    input  logic                 bvalid,
    output logic                 bready
);
    import remips_pkg::*;

    bridge_rd_state_e               rd_state;
    bridge_wr_state_e               wr_state;
    logic [$clog2(`LINE_WORDS)-1:0] beat;
    uint128_t                       line_q;

    // data reads win over instruction reads
    assign urd_rdy   = rd_state == RD_IDLE && urd_req;
    assign rd_rdy    = rd_state == RD_IDLE && rd_req && !urd_req;
    assign arvalid   = rd_state == RD_ADDR;
    assign rready    = rd_state == RD_DATA;
    assign ret_data  = line_q;
    assign uret_data = line_q[31:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state   <= RD_IDLE;
            ret_valid  <= 1'b0;
            uret_valid <= 1'b0;
        end else begin
            ret_valid  <= 1'b0;
            uret_valid <= 1'b0;
            case (rd_state)
                RD_IDLE: if (urd_rdy || rd_rdy) rd_state <= RD_ADDR;
                RD_ADDR: if (arready) rd_state <= RD_DATA;
                RD_DATA: begin
                    if (rvalid && rlast) begin
                        rd_state   <= RD_IDLE;
                        ret_valid  <= rid == `AXI_ID_INST;
                        uret_valid <= rid == `AXI_ID_DATA;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (urd_rdy) begin
            arid   <= `AXI_ID_DATA;
            araddr <= urd_addr;
            arlen  <= 8'd0;
            arsize <= urd_size;
        end else if (rd_rdy) begin
            arid   <= `AXI_ID_INST;
            araddr <= rd_addr;
            arlen  <= rd_uncache ? 8'd0 : 8'(`LINE_WORDS - 1);
            arsize <= 3'd2;
        end
        // beat 0 lands in the low word, so a single read is already in place
        if (arvalid && arready) begin
            beat <= '0;
        end else if (rvalid && rready) begin
            line_q[beat*32 +: 32] <= rdata;
            beat                  <= beat + 1'b1;
        end
    end

    // single writes only
    assign uwr_rdy = wr_state == WR_IDLE && uwr_req;
    assign awvalid = wr_state == WR_ADDR;
    assign wvalid  = wr_state == WR_DATA;
    assign bready  = wr_state == WR_RESP;
    assign wlast   = wvalid;
    assign awid    = `AXI_ID_DATA;
    assign wid     = `AXI_ID_DATA;
    assign awlen   = 8'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state   <= WR_IDLE;
            uwr_bvalid <= 1'b0;
        end else begin
            uwr_bvalid <= 1'b0;
            case (wr_state)
                WR_IDLE: if (uwr_rdy) wr_state <= WR_ADDR;
                WR_ADDR: if (awready) wr_state <= WR_DATA;
                WR_DATA: if (wready) wr_state <= WR_RESP;
                WR_RESP: begin
                    if (bvalid) begin
                        wr_state   <= WR_IDLE;
                        uwr_bvalid <= 1'b1;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (uwr_rdy) begin
            awaddr <= uwr_addr;
            awsize <= uwr_size;
            wstrb  <= uwr_wstrb;
            wdata  <= uwr_data;
        end
    end

    // slave ends each burst on the beat that arlen asks for
    a_rlast_len: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready |-> rlast == (beat == arlen[1:0]));

    // no error responses expected, no exceptions modeled
    a_rid_match: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready |-> rid == arid && rresp == 2'b00);

    a_bid_match: assert property (@(posedge clk) disable iff (rst)
        bvalid && bready |-> bid == awid && bresp == 2'b00);

endmodule

// ==== src/remips_mem.sv ====
`timescale 1ns/10ps

module remips_mem (
    input  logic                clk,
    input  logic                rst,
    // instruction fetch
    input  logic                inst_req,
    input  remips_pkg::virt_t   inst_addr,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,
    output remips_pkg::uint32_t inst_rdata,
    // data access
    input  logic                data_req,
    input  logic                data_wr,
    input  remips_pkg::size_t   data_size,
    input  remips_pkg::strb_t   data_wstrb,
    input  remips_pkg::virt_t   data_addr,
    input  remips_pkg::uint32_t data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    output remips_pkg::uint32_t data_rdata,
    // ar
    output logic [3:0]          arid,
    output remips_pkg::phys_t   araddr,
    output logic [7:0]          arlen,
    output remips_pkg::size_t   arsize,
    output logic                arvalid,
    input  logic                arready,
    // r
    input  logic [3:0]          rid,
    input  remips_pkg::uint32_t rdata,
    input  logic [1:0]          rresp,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready,
    // aw
    output logic [3:0]          awid,
    output remips_pkg::phys_t   awaddr,
    output logic [7:0]          awlen,
    output remips_pkg::size_t   awsize,
    output logic                awvalid,
    input  logic                awready,
    // w
    output logic [3:0]          wid,
    output remips_pkg::uint32_t wdata,
    output remips_pkg::strb_t   wstrb,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    // b
    input  logic [3:0]          bid,
    input  logic [1:0]          bresp,
    input  logic                bvalid,
    output logic                bready
);
    import remips_pkg::*;

    // icache to bridge
    logic     rd_req;
    logic     rd_uncache;
    phys_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    uint128_t ret_data;

    // uncached data path
    logic     urd_req;
    phys_t    urd_addr;
    size_t    urd_size;
    logic     urd_rdy;
    logic     uret_valid;
    uint32_t  uret_data;
    logic     uwr_req;
    phys_t    uwr_addr;
    size_t    uwr_size;
    strb_t    uwr_wstrb;
    uint32_t  uwr_data;
    logic     uwr_rdy;
    logic     uwr_bvalid;

    icache u_icache (.*);

    uncache_port u_uncache_port (.*);

    axi_bridge u_axi_bridge (.*);

endmodule

// ==== tests/mem_checker.sv ====
`timescale 1ns/10ps

module mem_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_req,
    input  remips_pkg::virt_t   inst_addr,
    input  logic                inst_addr_ok,
    input  logic                inst_data_ok,
    input  remips_pkg::uint32_t inst_rdata,
    input  logic                data_req,
    input  logic                data_wr,
    input  remips_pkg::strb_t   data_wstrb,
    input  remips_pkg::virt_t   data_addr,
    input  remips_pkg::uint32_t data_wdata,
    input  logic                data_addr_ok,
    input  logic                data_data_ok,
    input  remips_pkg::uint32_t data_rdata,
    input  remips_pkg::size_t   arsize,
    input  logic                arvalid,
    input  logic                arready,
    input  logic                rvalid,
    input  logic                rready,
    input  logic [3:0]          awid,
    input  logic [7:0]          awlen,
    input  remips_pkg::size_t   awsize,
    input  logic                awvalid,
    input  logic                awready,
    input  logic [3:0]          wid,
    input  logic                wlast,
    input  logic                wvalid,
    input  logic                wready
);
    import remips_pkg::*;

    // word index is address bits 13:2, same as the AXI memory model
    uint32_t ref_mem [4096];
    virt_t   inst_q[$];
    virt_t   data_q[$];
    logic    data_wr_q[$];
    virt_t   done_addr;
    logic    done_wr;
    int      inst_acc = 0;
    int      data_acc = 0;
    int      outstanding = 0;
    int      ar_cnt = 0;
    int      beat_cnt = 0;
    int      test_id = 0;
    int      exp_ar = 0;
    int      exp_beats = 0;
    int      row_errors = 0;
    int      tests = 0;
    int      failed = 0;
    int      errors = 0;

    task automatic check_word(input string what, input virt_t va, input uint32_t got);
        if (got !== ref_mem[va[13:2]]) begin
            $display("Fail at %0t: %s at %h returned %h, expected %h",
                     $time, what, va, got, ref_mem[va[13:2]]);
            row_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (inst_data_ok) begin
                if (inst_q.size() == 0) begin
                    $display("instruction data came back with no fetch outstanding");
                    row_errors++;
                end else begin
                    done_addr = inst_q.pop_front();
                    check_word("fetch", done_addr, inst_rdata);
                    outstanding--;
                end
            end
            if (data_data_ok) begin
                if (data_q.size() == 0) begin
                    $display("data port finished an access that was never accepted");
                    row_errors++;
                end else begin
                    done_addr = data_q.pop_front();
                    done_wr = data_wr_q.pop_front();
                    if (!done_wr) begin
                        check_word("load", done_addr, data_rdata);
                    end
                    outstanding--;
                end
            end
            if (inst_req && inst_addr_ok) begin
                inst_q.push_back(inst_addr);
                inst_acc++;
                outstanding++;
            end
            if (data_req && data_addr_ok) begin
                data_q.push_back(data_addr);
                data_wr_q.push_back(data_wr);
                data_acc++;
                outstanding++;
                // merge written bytes by strobe
                for (int k = 0; k < 4; k++) begin
                    if (data_wr && data_wstrb[k]) begin
                        ref_mem[data_addr[13:2]][8*k +: 8] = data_wdata[8*k +: 8];
                    end
                end
            end
            if (arvalid && arready) begin
                ar_cnt++;
                // every access in the table is a word access
                if (arsize != 3'd2) begin
                    $display("Fail at %0t: read burst size %0d, expected word size",
                             $time, arsize);
                    row_errors++;
                end
            end
            if (rvalid && rready) begin
                beat_cnt++;
            end
            if (awvalid && awready && (awlen != 8'd0 || awsize != 3'd2)) begin
                $display("Fail at %0t: write burst len %0d size %0d, expected one word",
                         $time, awlen, awsize);
                row_errors++;
            end
            if (wvalid && wready && (!wlast || wid != awid)) begin
                $display("Fail at %0t: write beat wlast %0b wid %0d, expected 1 and %0d",
                         $time, wlast, wid, awid);
                row_errors++;
            end
        end
    end

    task automatic begin_test(input int id, input int ar, input int beats);
        test_id = id;
        exp_ar = ar;
        exp_beats = beats;
        ar_cnt = 0;
        beat_cnt = 0;
        row_errors = 0;
    endtask

    task automatic end_test();
        if (ar_cnt != exp_ar || beat_cnt != exp_beats) begin
            $display("Fail at %0t: test %0d saw %0d bursts, %0d beats, expected %0d, %0d",
                     $time, test_id, ar_cnt, beat_cnt, exp_ar, exp_beats);
            row_errors++;
        end
        tests++;
        if (row_errors == 0) begin
            $display("test %0d passed", test_id);
        end else begin
            $display("test %0d failed with %0d errors", test_id, row_errors);
            failed++;
            errors += row_errors;
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests, tests - failed, failed, errors);
    endtask

endmodule

// ==== tests/tb_remips_mem.sv ====
`timescale 1ns/10ps

module tb_remips_mem;
    import remips_pkg::*;

    localparam int P_INST = 0;
    localparam int P_DATA = 1;
    localparam int P_BOTH = 2;
    localparam int MEM_WORDS = 4096;

    logic    clk;
    logic    rst;
    logic    inst_req, inst_addr_ok, inst_data_ok;
    virt_t   inst_addr;
    uint32_t inst_rdata;
    logic    data_req, data_wr, data_addr_ok, data_data_ok;
    size_t   data_size;
    strb_t   data_wstrb;
    virt_t   data_addr;
    uint32_t data_wdata, data_rdata;
    logic [3:0] arid, rid, awid, wid, bid;
    phys_t   araddr, awaddr;
    logic [7:0] arlen, awlen;
    size_t   arsize, awsize;
    logic    arvalid, arready, rlast, rvalid, rready;
    logic    awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    uint32_t rdata, wdata;
    strb_t   wstrb;
    logic [1:0] rresp, bresp;

    // AXI memory model state
    integer  seed = 32'ha93d;
    uint32_t mem [MEM_WORDS];
    logic    ar_hs, r_hs, aw_hs, w_hs, b_hs;
    phys_t   ar_addr_c, aw_addr_c;
    logic [7:0] ar_len_c;
    logic [3:0] ar_id_c, aw_id_c;
    uint32_t wdata_c;
    strb_t   wstrb_c;
    logic    r_busy, b_pend;
    logic [11:0] r_idx, w_idx;
    logic [7:0] r_left;
    logic [3:0] r_id;

    // stimulus table, one entry per column
    int      row_port[$];
    logic    row_wr[$];
    virt_t   row_addr[$];
    virt_t   row_addr2[$];
    uint32_t row_wdata[$];
    strb_t   row_strb[$];
    int      row_ar[$];
    int      row_beats[$];
    int      n_rows = 0;

    remips_mem UUT (.*);

    mem_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic coin();
        integer r;
        r = $random(seed);
        return r[0] | r[1];
    endfunction

    always @(posedge clk) begin
        ar_hs <= !rst && arvalid && arready;
        ar_addr_c <= araddr;
        ar_len_c <= arlen;
        ar_id_c <= arid;
        r_hs <= !rst && rvalid && rready;
        aw_hs <= !rst && awvalid && awready;
        aw_addr_c <= awaddr;
        aw_id_c <= awid;
        w_hs <= !rst && wvalid && wready;
        wdata_c <= wdata;
        wstrb_c <= wstrb;
        b_hs <= !rst && bvalid && bready;
    end

    // handshakes seen at the last rising edge are acted on here
    always @(negedge clk) begin
        if (ar_hs) begin
            r_busy = 1'b1;
            r_idx = ar_addr_c[13:2];
            r_left = ar_len_c;
            r_id = ar_id_c;
        end
        if (r_hs) begin
            rvalid = 1'b0;
            if (r_left == 8'd0) begin
                r_busy = 1'b0;
            end else begin
                r_left = r_left - 8'd1;
                r_idx = r_idx + 12'd1;
            end
        end
        if (r_busy && !rvalid && coin()) begin
            rvalid = 1'b1;
            rdata = mem[r_idx];
            rid = r_id;
            rlast = r_left == 8'd0;
        end
        if (aw_hs) begin
            w_idx = aw_addr_c[13:2];
            bid = aw_id_c;
        end
        if (w_hs) begin
            for (int k = 0; k < 4; k++) begin
                if (wstrb_c[k]) begin
                    mem[w_idx][8*k +: 8] = wdata_c[8*k +: 8];
                end
            end
            b_pend = 1'b1;
        end
        if (b_hs) begin
            bvalid = 1'b0;
            b_pend = 1'b0;
        end
        if (b_pend && !bvalid && coin()) begin
            bvalid = 1'b1;
        end
        arready = coin();
        awready = coin();
        wready = coin();
    end

    task automatic add_row(input int port, input logic wr, input virt_t addr, input virt_t addr2,
                           input uint32_t wd, input strb_t strb, input int ar, input int beats);
        row_port.push_back(port);
        row_wr.push_back(wr);
        row_addr.push_back(addr);
        row_addr2.push_back(addr2);
        row_wdata.push_back(wd);
        row_strb.push_back(strb);
        row_ar.push_back(ar);
        row_beats.push_back(beats);
    endtask

    task automatic build_table();
        // cold miss, hits in the same line, then eviction at index 4
        add_row(P_INST, 1'b0, 32'h8000_0040, 32'h0, 32'h0, 4'h0, 1, 4);
        add_row(P_INST, 1'b0, 32'h8000_0048, 32'h0, 32'h0, 4'h0, 0, 0);
        add_row(P_INST, 1'b0, 32'h8000_004c, 32'h0, 32'h0, 4'h0, 0, 0);
        add_row(P_INST, 1'b0, 32'h8000_0040, 32'h0, 32'h0, 4'h0, 0, 0);
        add_row(P_INST, 1'b0, 32'h8000_1040, 32'h0, 32'h0, 4'h0, 1, 4);
        add_row(P_INST, 1'b0, 32'h8000_0044, 32'h0, 32'h0, 4'h0, 1, 4);
        // kseg1 fetches never allocate
        add_row(P_INST, 1'b0, 32'ha000_0200, 32'h0, 32'h0, 4'h0, 1, 1);
        add_row(P_INST, 1'b0, 32'ha000_0200, 32'h0, 32'h0, 4'h0, 1, 1);
        add_row(P_DATA, 1'b1, 32'ha000_0300, 32'h0, 32'h1122_3344, 4'b0101, 0, 0);
        add_row(P_DATA, 1'b0, 32'ha000_0300, 32'h0, 32'h0, 4'h0, 1, 1);
        add_row(P_DATA, 1'b1, 32'ha000_0304, 32'h0, 32'hdead_beef, 4'b1100, 0, 0);
        add_row(P_DATA, 1'b0, 32'ha000_0304, 32'h0, 32'h0, 4'h0, 1, 1);
        // data read racing an instruction refill
        add_row(P_BOTH, 1'b0, 32'h8000_0380, 32'ha000_0500, 32'h0, 4'h0, 2, 5);
        add_row(P_BOTH, 1'b0, 32'h8000_2080, 32'ha000_0304, 32'h0, 4'h0, 2, 5);
        add_row(P_INST, 1'b0, 32'h8000_2084, 32'h0, 32'h0, 4'h0, 0, 0);
        n_rows = row_port.size();
    endtask

    task automatic apply_row(input int i);
        int   inst_seen;
        int   data_seen;
        logic inst_wait;
        logic data_wait;
        inst_seen = chk.inst_acc;
        data_seen = chk.data_acc;
        inst_wait = row_port[i] != P_DATA;
        data_wait = row_port[i] != P_INST;
        chk.begin_test(i, row_ar[i], row_beats[i]);
        @(negedge clk);
        inst_req = inst_wait;
        inst_addr = row_addr[i];
        data_req = data_wait;
        data_wr = row_wr[i];
        data_size = 3'd2;
        data_wstrb = row_strb[i];
        data_addr = row_port[i] == P_BOTH ? row_addr2[i] : row_addr[i];
        data_wdata = row_wdata[i];
        while (inst_wait || data_wait) begin
            @(negedge clk);
            if (chk.inst_acc != inst_seen) begin
                inst_wait = 1'b0;
                inst_req = 1'b0;
            end
            if (chk.data_acc != data_seen) begin
                data_wait = 1'b0;
                data_req = 1'b0;
            end
        end
        while (chk.outstanding != 0) begin
            @(negedge clk);
        end
        chk.end_test();
    endtask

    initial begin
        rst = 1'b1;
        inst_req = 1'b0;
        inst_addr = '0;
        data_req = 1'b0;
        data_wr = 1'b0;
        data_size = 3'd2;
        data_wstrb = '0;
        data_addr = '0;
        data_wdata = '0;
        arready = 1'b0;
        rid = '0;
        rdata = '0;
        rresp = 2'b00;
        rlast = 1'b0;
        rvalid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bid = '0;
        bresp = 2'b00;
        bvalid = 1'b0;
        r_busy = 1'b0;
        b_pend = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
            chk.ref_mem[i] = mem[i];
        end
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        chk.report();
        if (chk.errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (n_rows > 0);
        repeat (n_rows * 200 + 8) @(posedge clk);
        $display("watchdog expired, a core-side access never completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== remips_mem.f ====
+incdir+common
common/remips_pkg.sv
icache/icache.sv
src/uncache_port.sv
src/axi_bridge.sv
src/remips_mem.sv
tests/mem_checker.sv
tests/tb_remips_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_remips_mem -f remips_mem.f
./obj_dir/Vtb_remips_mem | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation log is clean"
